// File: icache_top.f
src/icache_pkg.sv
src/icache_mem_if.sv
src/icache_ctrl.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_mem_port.sv
src/icache_top.sv
dv/icache_asserts.sv
dv/icache_tb.sv

// File: Makefile
# Verilator flow for the instruction cache testbench
TOP = icache_tb
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f icache_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f icache_top.f \
	  --top-module $(TOP) --Mdir $(OBJ) -o $(TOP)_sim
	@out="$$(./$(OBJ)/$(TOP)_sim)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ)

// File: dv/icache_tb.sv
`timescale 1ns/100ps

module icache_tb
  import icache_pkg::*;
();

  // data pattern of the memory model
  localparam logic [XLEN-1:0] DATA_KEY = 32'h5a5a_0000;
  // roughly 130 fetches, each well under 150 cycles even with stalls
  localparam int MAX_FETCHES = 130;
  localparam int WORST_FETCH = 150;
  localparam int TIMEOUT_CYCLES = MAX_FETCHES * WORST_FETCH + 500;

  logic              clk = 1'b0;
  logic              rst;
  logic [XLEN-1:0]   fetch_addr;
  logic              fetch_valid;
  logic [XLEN-1:0]   fetch_rdata;
  logic              fetch_rdata_valid;
  logic [XLEN-1:0]   mem_raddr;
  logic              mem_raddr_valid;
  logic [RLEN_W-1:0] mem_rlen;
  logic              mem_rdata_ready = 1'b0;
  logic [XLEN-1:0]   mem_rdata = '0;

  // memory model and monitor state
  logic [31:0]       rng = 32'hfbf6e0db;
  logic              stalls_on = 1'b0;
  logic              beat_taken = 1'b0;
  logic              req_seen = 1'b0;
  int                beat_cnt = 0;
  int                burst_count = 0;
  int                single_count = 0;
  logic [XLEN-1:0]   last_req_addr = '0;
  logic [RLEN_W-1:0] last_req_rlen = '0;

  // bookkeeping
  string             test_name;
  int                test_errors0;
  int                tests_run = 0;
  int                checks = 0;
  int                errors = 0;
  int                cycle_count;

  always #2 clk = ~clk;

  icache_top icache_top_i (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .mem_raddr_o         (mem_raddr),
    .mem_raddr_valid_o   (mem_raddr_valid),
    .mem_rlen_o          (mem_rlen),
    .mem_rdata_ready_i   (mem_rdata_ready),
    .mem_rdata_i         (mem_rdata)
  );

  bind icache_top icache_asserts u_asserts (
    .clk                 (clk),
    .rst                 (rst),
    .mem_raddr_i         (mem_raddr_o),
    .mem_raddr_valid_i   (mem_raddr_valid_o),
    .mem_rlen_i          (mem_rlen_o),
    .fetch_rdata_valid_i (fetch_rdata_valid_o),
    .state_i             (u_ctrl.state_q),
    .done_i              (mem_if.done)
  );

  // word stored at byte address a
  function automatic logic [XLEN-1:0] model_word(input logic [XLEN-1:0] a);
    return a ^ DATA_KEY;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory model, beat k of a request returns the word at base + 4k
  always @(posedge clk) begin
    #0.5;
    if (!mem_raddr_valid) begin
      beat_cnt = 0;
    end else if (beat_taken) begin
      beat_cnt = beat_cnt + 1;
    end
    mem_rdata_ready = 1'b1;
    if (stalls_on) begin
      rng = xorshift32(rng);
      // ready about three cycles in four
      mem_rdata_ready = (rng[1:0] != 2'b00);
    end
    mem_rdata  = model_word(mem_raddr + 32'(4 * beat_cnt));
    beat_taken = mem_raddr_valid && mem_rdata_ready;
  end

  // request monitor, one count per rising valid
  always @(posedge clk) begin
    #0.5;
    if (mem_raddr_valid && !req_seen) begin
      if (mem_rlen == BURST_RLEN) begin
        burst_count = burst_count + 1;
      end else begin
        single_count = single_count + 1;
      end
      last_req_addr = mem_raddr;
      last_req_rlen = mem_rlen;
    end
    req_seen = mem_raddr_valid;
  end

  task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] got);
    checks++;
    assert (got === exp) else begin
      $display("error in %s, %s: expected %h, got %h", test_name, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s: %s", test_name, msg);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    test_errors0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors0) begin
      $display("test %s: pass", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, errors - test_errors0);
    end
  endtask

  // present addr and wait for the answer, ends at the answer cycle
  task automatic fetch(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data,
                       output int lat);
    fetch_addr  = addr;
    fetch_valid = 1'b1;
    data        = 'x;
    lat         = 0;
    do begin
      @(posedge clk);
      #0.5;
      lat++;
    end while (!fetch_rdata_valid && lat < WORST_FETCH);
    check_true(fetch_rdata_valid, $sformatf("fetch at %h got no answer", addr));
    if (fetch_rdata_valid) data = fetch_rdata;
  endtask

  // drop valid in the answer cycle, then let the FSM settle
  task automatic end_fetch();
    fetch_valid = 1'b0;
    @(posedge clk);
    #0.5;
  endtask

  task automatic reset_first_fetch();
    logic [XLEN-1:0] data;
    int              lat;
    int              bursts0;
    start_test("reset_first_fetch");
    check_value("request valid after reset", '0, 32'(mem_raddr_valid));
    check_value("fetch valid after reset", '0, 32'(fetch_rdata_valid));
    bursts0 = burst_count;
    fetch(32'h8000_0048, data, lat);
    check_value("word", model_word(32'h8000_0048), data);
    check_value("bursts", 32'(bursts0 + 1), 32'(burst_count));
    // line aligned base, full line length
    check_value("burst address", 32'h8000_0040, last_req_addr);
    check_value("burst length", 32'(BURST_RLEN), 32'(last_req_rlen));
    end_fetch();
    end_test();
  endtask

  task automatic sequential_lines(input string name, input logic [XLEN-1:0] base);
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    int              lat;
    int              bursts0;
    int              line;
    int              w;
    start_test(name);
    bursts0 = burst_count;
    // two whole lines back to back, one burst each
    for (line = 0; line < 2; line++) begin
      for (w = 0; w < BEATS_PER_LINE; w++) begin
        addr = base + 32'(line * 64 + w * 4);
        fetch(addr, data, lat);
        check_value("word", model_word(addr), data);
      end
      check_value("bursts", 32'(bursts0 + line + 1), 32'(burst_count));
    end
    // first line again, all hits
    for (w = 0; w < BEATS_PER_LINE; w++) begin
      addr = base + 32'(w * 4);
      fetch(addr, data, lat);
      check_value("repeat word", model_word(addr), data);
      check_value("hit latency", 32'd1, 32'(lat));
    end
    check_value("bursts after repeat", 32'(bursts0 + 2), 32'(burst_count));
    end_fetch();
    end_test();
  endtask

  // a and b share an index but not a tag
  task automatic evict_pair(input string name, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    int              lat;
    int              bursts0;
    int              i;
    start_test(name);
    bursts0 = burst_count;
    for (i = 0; i < 6; i++) begin
      addr = ((i % 2) == 0 ? a : b) + 32'(4 * i);
      fetch(addr, data, lat);
      check_value("word", model_word(addr), data);
      check_value("bursts", 32'(bursts0 + i + 1), 32'(burst_count));
    end
    end_fetch();
    end_test();
  endtask

  // resident is a cached address with the same index as base
  task automatic uncached_reads(input string name, input logic [XLEN-1:0] base,
                                input logic [XLEN-1:0] resident);
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] aligned;
    logic [XLEN-1:0] data;
    int              lat;
    int              bursts0;
    int              singles0;
    int              i;
    start_test(name);
    bursts0 = burst_count;
    // same address twice, then a byte offset inside the next word
    for (i = 0; i < 3; i++) begin
      addr     = (i == 2) ? base + 32'd6 : base;
      aligned  = addr & 32'hffff_fffc;
      singles0 = single_count;
      fetch(addr, data, lat);
      check_value("word", model_word(aligned), data);
      check_value("single reads", 32'(singles0 + 1), 32'(single_count));
      check_value("single address", aligned, last_req_addr);
      check_value("single length", 32'(SINGLE_RLEN), 32'(last_req_rlen))
;
    end
    // cached line at that index untouched by the device reads
    fetch(resident, data, lat);
    check_value("resident word", model_word(resident), data);
    check_value("resident hit latency", 32'd1, 32'(lat));
    check_value("bursts", 32'(bursts0), 32'(burst_count));
    end_fetch();
    end_test();
  endtask

  // tests 2 to 4 on fresh lines with ready stalls
  task automatic stalled_repeat();
    stalls_on = 1'b1;
    sequential_lines("sequential_stalled", 32'h8010_1000);
    evict_pair("eviction_stalled", 32'h8011_0080, 32'h8012_0080);
    uncached_reads("uncached_stalled", 32'h0000_3010, 32'h8010_1010);
    stalls_on = 1'b0;
  endtask

  initial begin
    rst         = 1'b1;
    fetch_addr  = '0;
    fetch_valid = 1'b0;
    repeat (16) @(posedge clk);
    #0.5;
    rst = 1'b0;
    reset_first_fetch();
    sequential_lines("sequential", 32'h8000_1000);
    evict_pair("eviction", 32'h8001_0080, 32'h8002_0080);
    uncached_reads("uncached", 32'h0000_1000, 32'h8000_1008);
    stalled_repeat();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: dv/icache_asserts.sv
`timescale 1ns/100ps

module icache_asserts
  import icache_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic [XLEN-1:0]   mem_raddr_i,
  input logic              mem_raddr_valid_i,
  input logic [RLEN_W-1:0] mem_rlen_i,
  input logic              fetch_rdata_valid_i,
  // controller state and last-beat pulse
  input icache_state_e     state_i,
  input logic              done_i
);

  // no request open as reset ends
  reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !mem_raddr_valid_i)
    else $error("memory request valid in the cycle after reset");

  // address and length held until the last beat
  req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_raddr_valid_i && !done_i
      |=> mem_raddr_valid_i && $stable(mem_raddr_i) && $stable(mem_rlen_i))
    else $error("memory request changed or dropped before its last beat");

  // refill bursts start on a line boundary
  burst_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_raddr_valid_i && (mem_rlen_i == BURST_RLEN)
      |-> (mem_raddr_i[OFFSET_W-1:0] == '0))
    else $error("burst request address not line aligned");

  // answers come from a lookup or one cycle after an uncached done
  fetch_source: assert property (@(posedge clk) disable iff (rst)
    fetch_rdata_valid_i
      |-> (state_i == ST_LOOKUP)
          || (($past(state_i) == ST_UNCACHED) && $past(done_i)))
    else $error("fetch valid outside lookup and uncached return");

endmodule

// File: src/icache_top.sv
`timescale 1ns/100ps

module icache_top
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // fetch side
  input  logic [XLEN-1:0]   fetch_addr_i,
  input  logic              fetch_valid_i,
  output logic [XLEN-1:0]   fetch_rdata_o,
  output logic              fetch_rdata_valid_o,
  // memory read port
  output logic [XLEN-1:0]   mem_raddr_o,
  output logic              mem_raddr_valid_o,
  output logic [RLEN_W-1:0] mem_rlen_o,
  input  logic              mem_rdata_ready_i,
  input  logic [XLEN-1:0]   mem_rdata_i
);

  logic                  hit;
  logic [XLEN-1:0]       tag_addr;
  logic                  tag_write;
  logic [INDEX_W-1:0]    rd_index;
  logic [WORD_SEL_W-1:0] rd_word;
  logic [XLEN-1:0]       rd_data;

  // controller to memory port link
  icache_mem_if mem_if ();

  icache_ctrl u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_rdata_o       (fetch_rdata_o),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .hit_i               (hit),
    .tag_addr_o          (tag_addr),
    .tag_write_o         (tag_write),
    .rd_index_o          (rd_index),
    .rd_word_o           (rd_word),
    .rd_data_i           (rd_data),
    .mem                 (mem_if.ctrl)
  );

  icache_tag_store u_tag_store (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (tag_addr),
    .write_i (tag_write),
    .hit_o   (hit)
  );

  // refill line index is the held fetch address index
  icache_data_store u_data_store (
    .clk        (clk),
    .rd_index_i (rd_index),
    .rd_word_i  (rd_word),
    .rd_data_o  (rd_data),
    .wr_index_i (tag_addr[OFFSET_W +: INDEX_W]),
    .mem        (mem_if.store)
  );

  icache_mem_port u_mem_port (
    .clk               (clk),
    .rst               (rst),
    .mem               (mem_if.port),
    .mem_raddr_o       (mem_raddr_o),
    .mem_raddr_valid_o (mem_raddr_valid_o),
    .mem_rlen_o        (mem_rlen_o),
    .mem_rdata_ready_i (mem_rdata_ready_i),
    .mem_rdata_i       (mem_rdata_i)
  );

endmodule

// File: src/icache_mem_port.sv
`timescale 1ns/100ps

module icache_mem_port
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // controller side
  icache_mem_if.port        mem,
  // memory read port
  output logic [XLEN-1:0]   mem_raddr_o,
  output logic              mem_raddr_valid_o,
  output logic [RLEN_W-1:0] mem_rlen_o,
  input  logic              mem_rdata_ready_i,
  input  logic [XLEN-1:0]   mem_rdata_i
);

  logic [XLEN-1:0]       raddr_q;
  logic [RLEN_W-1:0]     rlen_q;
  logic                  valid_q;
  logic [WORD_SEL_W-1:0] cnt_q;
  logic [XLEN-1:0]       req_addr;
  logic                  beat;
  logic                  last;

  // line aligned for a refill, word aligned for a device read
  always_comb begin
    if (mem.uncached) begin
      req_addr = {mem.addr[XLEN-1:OFFSET_W], mem.read_word, {WORD_LSB{1'b0}}};
    end else begin
      req_addr = {mem.addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
  end

  // one beat per cycle with valid and ready both high
  assign beat = valid_q && mem_rdata_ready_i;
  // count reaches the length code on the final beat
  assign last = (cnt_q == rlen_q[WORD_SEL_W-1:0]);

  // request valid and beat counter
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (mem.req) begin
      // controller only requests with nothing open
      valid_q <= 1'b1;
      cnt_q   <= '0;
    end else if (beat) begin
      if (last) begin
        valid_q <= 1'b0;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // address and length, held for the whole request
  always_ff @(posedge clk) begin
    if (mem.req) begin
      raddr_q <= req_addr;
      rlen_q  <= mem.uncached ? SINGLE_RLEN : BURST_RLEN;
    end
  end

  // beat reports back to the controller and data store
  assign mem.beat     = beat;
  assign mem.beat_idx = cnt_q;
  assign mem.done     = beat && last;
  // returned word passes straight through
  assign mem.rdata    = mem_rdata_i;

  assign mem_raddr_o       = raddr_q;
  assign mem_raddr_valid_o = valid_q;
  assign mem_rlen_o        = rlen_q;

endmodule

// File: src/icache_data_store.sv
`timescale 1ns/100ps

module icache_data_store
  import icache_pkg::*;
(
  input  logic                  clk,
  // read port
  input  logic [INDEX_W-1:0]    rd_index_i,
  input  logic [WORD_SEL_W-1:0] rd_word_i,
  output logic [XLEN-1:0]       rd_data_o,
  // refill write port
  input  logic [INDEX_W-1:0]    wr_index_i,
  icache_mem_if.store           mem
);

  // 128 lines of 16 words, flat word array
  logic [XLEN-1:0] words_q [NUM_LINES*BEATS_PER_LINE];
  logic            wr_en;

  // only refill beats land in the array
  assign wr_en = mem.beat && !mem.uncached;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      words_q[{wr_index_i, mem.beat_idx}] <= mem.rdata;
    end
  end

  // read data one cycle after the read address
  always_ff @(posedge clk) begin
    rd_data_o <= words_q[{rd_index_i, rd_word_i}];
  end

endmodule

// File: src/icache_tag_store.sv
`timescale 1ns/100ps

module icache_tag_store
  import icache_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] addr_i,
  input  logic            write_i,
  output logic            hit_o
);

  logic [NUM_LINES-1:0] valid_q;
  logic [TAG_W-1:0]     tags_q [NUM_LINES];
  logic [INDEX_W-1:0]   index;
  logic [TAG_W-1:0]     tag;

  // offset bits of addr_i play no part here
  assign index = addr_i[OFFSET_W +: INDEX_W];
  assign tag   = addr_i[XLEN-1 -: TAG_W];

  // valid bits, all lines empty after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_i) begin
      valid_q[index] <= 1'b1;
    end
  end

  // tag array
  always_ff @(posedge clk) begin
    if (write_i) begin
      tags_q[index] <= tag;
    end
  end

  // combinational compare on the registered address
  // new entry visible from the edge after write_i
  assign hit_o = valid_q[index] && (tags_q[index] == tag);

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // fetch side
  input  logic [XLEN-1:0]       fetch_addr_i,
  input  logic                  fetch_valid_i,
  output logic [XLEN-1:0]       fetch_rdata_o,
  output logic                  fetch_rdata_valid_o,
  // tag store
  input  logic                  hit_i,
  output logic [XLEN-1:0]       tag_addr_o,
  output logic                  tag_write_o,
  // data store
  output logic [INDEX_W-1:0]    rd_index_o,
  output logic [WORD_SEL_W-1:0] rd_word_o,
  input  logic [XLEN-1:0]       rd_data_i,
  // memory port
  icache_mem_if.ctrl            mem
);

  icache_state_e   state_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] unc_data_q;
  logic            unc_valid_q;
  logic            lookup;
  logic            addr_unc;
  logic            hit_ok;
  logic            accept;

  // fetch address held until its answer goes out
  assign lookup   = (state_q == ST_LOOKUP);
  assign addr_unc = is_uncached(addr_q);
  assign hit_ok   = lookup && hit_i;
  // cycles where a new fetch address may be taken
  assign accept   = (state_q == ST_IDLE) || hit_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_RST;
      unc_valid_q <= 1'b0;
    end else begin
      // single cycle answer pulse for uncached reads
      unc_valid_q <= 1'b0;
      case (state_q)
        ST_RST: state_q <= ST_IDLE;
        ST_IDLE: begin
          if (fetch_valid_i) state_q <= ST_LOOKUP;
        end
        ST_LOOKUP: begin
          if (addr_unc) begin
            state_q <= ST_UNCACHED;
          end else if (hit_i) begin
            // next fetch sampled while this one is answered
            if (!fetch_valid_i) state_q <= ST_IDLE;
          end else begin
            state_q <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (mem.done) state_q <= ST_RESUME;
        end
        // array re-read of the refilled word
        ST_RESUME: state_q <= ST_LOOKUP;
        ST_UNCACHED: begin
          if (mem.done) begin
            unc_valid_q <= 1'b1;
            state_q     <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // fetch address and uncached word
  always_ff @(posedge clk) begin
    if (accept && fetch_valid_i) addr_q <= fetch_addr_i;
    if (state_q == ST_UNCACHED && mem.done) unc_data_q <= mem.rdata;
  end

  // request pulse in the lookup cycle on a miss or device address
  assign mem.req       = lookup && (addr_unc || !hit_i);
  // stays stable while the request is open, addr_q is held
  assign mem.uncached  = addr_unc;
  assign mem.addr      = addr_q;
  assign mem.read_word = addr_q[WORD_LSB +: WORD_SEL_W];

  assign tag_addr_o  = addr_q;
  // line becomes valid with the last refill beat
  assign tag_write_o = (state_q == ST_REFILL) && mem.done;

  // incoming address when accepting, held address otherwise
  assign rd_index_o = accept ? fetch_addr_i[OFFSET_W +: INDEX_W]
                             : addr_q[OFFSET_W +: INDEX_W];
  assign rd_word_o  = accept ? fetch_addr_i[WORD_LSB +: WORD_SEL_W]
                             : addr_q[WORD_LSB +: WORD_SEL_W];

  assign fetch_rdata_valid_o = hit_ok || unc_valid_q;
  assign fetch_rdata_o       = unc_valid_q ? unc_data_q : rd_data_i;

endmodule

// File: src/icache_mem_if.sv
`timescale 1ns/100ps

interface icache_mem_if
  import icache_pkg::*;
();

  // request side, driven by the controller
  logic                  req;
  logic                  uncached;
  logic [XLEN-1:0]       addr;
  logic [WORD_SEL_W-1:0] read_word;

  // return side, driven by the memory port
  logic                  beat;
  logic [WORD_SEL_W-1:0] beat_idx;
  logic                  done;
  logic [XLEN-1:0]       rdata;

  modport ctrl (
    output req, uncached, addr, read_word,
    input  beat, beat_idx, done, rdata
  );

  modport port (
    input  req, uncached, addr, read_word,
    output beat, beat_idx, done, rdata
  );

  // refill writes into the data array, uncached beats are skipped
  modport store (
    input beat, beat_idx, rdata, uncached
  );

endinterface

// File: src/icache_pkg.sv
package icache_pkg;

  // address and instruction word width
  localparam int XLEN = 32;

  // address split: tag | index | byte offset
  localparam int TAG_W = 19;
  localparam int INDEX_W = 7;
  localparam int OFFSET_W = 6;
  localparam int NUM_LINES = 128;

  // 16 words of 4 bytes per 64 byte line
  localparam int WORD_SEL_W = 4;
  localparam int BEATS_PER_LINE = 16;
  // lowest address bit of the word select
  localparam int WORD_LSB = OFFSET_W - WORD_SEL_W;

  // memory length code is beats minus one
  localparam int RLEN_W = 8;
  localparam logic [RLEN_W-1:0] BURST_RLEN = RLEN_W'(BEATS_PER_LINE - 1);
  localparam logic [RLEN_W-1:0] SINGLE_RLEN = '0;

  // device region has this bit clear
  localparam int UNCACHED_BIT = 31;

  function automatic logic is_uncached(input logic [XLEN-1:0] addr);
    return ~addr[UNCACHED_BIT];
  endfunction

  typedef enum logic [2:0] {
    ST_RST,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_RESUME,
    ST_UNCACHED
  } icache_state_e;

endpackage
